// ==== design/rd_demux_pkg.sv ====
//--------------------------------------------------------------------------
// sizes and vector types shared by the read demux RTL and its testbench
// NUM_PORTS must be a power of two so that sel_t covers every port exactly
// a counter at all ones counts as full, so at most 2**CNT_W-1 bursts per ID
//--------------------------------------------------------------------------

package rd_demux_pkg;

  //--------------------------------------------------------------------------
  // sizes
  //--------------------------------------------------------------------------

  // downstream ports and the select width that names one of them
  localparam int NUM_PORTS = 4;
  localparam int SEL_W     = $clog2(NUM_PORTS);

  // AXI read channel field widths
  localparam int ID_W   = 4;
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 4;

  // low ID bits that pick a tracker slot
  localparam int LOOK_W   = 2;
  localparam int NUM_LOOK = 2 ** LOOK_W;

  // in-flight bursts per slot, all ones means full
  localparam int CNT_W = 3;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [ID_W-1:0]      id_t;
  typedef logic [LOOK_W-1:0]    look_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  // beats minus one, as on the AXI len field
  typedef logic [LEN_W-1:0]     len_t;
  typedef logic [SEL_W-1:0]     sel_t;
  // one bit per downstream port
  typedef logic [NUM_PORTS-1:0] port_vec_t;
  typedef logic [CNT_W-1:0]     cnt_t;

endpackage

// ==== design/rd_track_if.sv ====
//--------------------------------------------------------------------------
// traffic between the AR router, the response arbiter and the ID tracker
// lookup is combinational, push and pop take effect at the next clock edge
//--------------------------------------------------------------------------

`timescale 1ns/10ps

interface rd_track_if;
  import rd_demux_pkg::*;

  // lookup of the ID offered on the AR channel
  look_t lookup_id;
  sel_t  lookup_sel;
  logic  lookup_busy;
  // some slot has reached its maximum count
  logic  full;

  // new burst accepted on the AR channel
  logic  push;
  look_t push_id;
  sel_t  push_sel;

  // last beat of a burst accepted upstream
  logic  pop;
  look_t pop_id;

  modport router (output lookup_id, push, push_id, push_sel,
                  input  lookup_sel, lookup_busy, full);

  modport tracker (input  lookup_id, push, push_id, push_sel,
                   output lookup_sel, lookup_busy, full);

  modport arbiter (output pop, pop_id);

endinterface

// ==== design/ar_router.sv ====
//--------------------------------------------------------------------------
// AR acceptance and steering; ar_sel_i must name a port below NUM_PORTS
// upstream valid and payload must hold until ar_ready_o, per AXI rules
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module ar_router (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // upstream AR handshake with its port select
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  rd_demux_pkg::id_t      ar_id_i,
  input  rd_demux_pkg::sel_t     ar_sel_i,
  // downstream AR handshakes
  output rd_demux_pkg::port_vec_t m_ar_valid_o,
  input  rd_demux_pkg::port_vec_t m_ar_ready_i,
  // lookup and push towards the tracker
  rd_track_if.router             trk
);
  import rd_demux_pkg::*;

  // valid is held once offered downstream without a ready
  logic lock_q;
  logic lock_d;
  // request passes the ID check and goes out this cycle
  logic ar_valid;
  logic ar_hs;
  // ID idle, or already bound to the same port
  logic id_ok;

  // tracker lookup uses the low ID bits of the offered request
  assign trk.lookup_id = ar_id_i[LOOK_W-1:0];
  assign id_ok         = !trk.lookup_busy || (trk.lookup_sel == ar_sel_i);

  //--------------------------------------------------------------------------
  // acceptance
  //--------------------------------------------------------------------------

  always_comb begin
    ar_valid = 1'b0;
    if (lock_q) begin
      // already offered, tracker changes must not withdraw it
      ar_valid = 1'b1;
    end else if (ar_valid_i && !trk.full && id_ok) begin
      ar_valid = 1'b1;
    end
  end

  assign ar_hs      = ar_valid & m_ar_ready_i[ar_sel_i];
  assign ar_ready_o = ar_hs;
  // keep offering while the selected port stalls
  assign lock_d     = ar_valid & ~ar_hs;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // only the selected port sees a valid
  assign m_ar_valid_o = ar_valid ? port_vec_t'(1) << ar_sel_i : '0;

  // record the burst in the handshake cycle
  assign trk.push     = ar_hs;
  assign trk.push_id  = ar_id_i[LOOK_W-1:0];
  assign trk.push_sel = ar_sel_i;

endmodule

// ==== design/id_tracker.sv ====
//--------------------------------------------------------------------------
// in-flight bursts per low-ID slot and the port each slot is bound to
// a pop to an empty slot is not guarded and wraps the count
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module id_tracker (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // lookup and push from the AR router
  rd_track_if.tracker      trk_r,
  // pop from the response arbiter, same instance as trk_r
  rd_track_if              trk_a
);
  import rd_demux_pkg::*;

  // one counter and one stored select per slot
  cnt_t [NUM_LOOK-1:0] cnt_q;
  cnt_t [NUM_LOOK-1:0] cnt_d;
  sel_t [NUM_LOOK-1:0] sel_q;
  // per-slot decoded push and pop strobes
  logic [NUM_LOOK-1:0] push_en;
  logic [NUM_LOOK-1:0] pop_en;
  logic [NUM_LOOK-1:0] cnt_full;

  //--------------------------------------------------------------------------
  // lookup
  //--------------------------------------------------------------------------

  assign trk_r.lookup_sel  = sel_q[trk_r.lookup_id];
  assign trk_r.lookup_busy = |cnt_q[trk_r.lookup_id];
  // one saturated slot stops every new request
  assign trk_r.full        = |cnt_full;

  //--------------------------------------------------------------------------
  // counters
  //--------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_LOOK; i++) begin
      push_en[i]  = trk_r.push && (trk_r.push_id == look_t'(i));
      pop_en[i]   = trk_a.pop && (trk_a.pop_id == look_t'(i));
      cnt_full[i] = &cnt_q[i];
      unique case ({push_en[i], pop_en[i]})
        2'b10: begin
          cnt_d[i] = cnt_q[i] + cnt_t'(1);
        end
        2'b01: begin
          cnt_d[i] = cnt_q[i] - cnt_t'(1);
        end
        // push and pop together cancel out
        default: begin
          cnt_d[i] = cnt_q[i];
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //--------------------------------------------------------------------------
  // port binding
  //--------------------------------------------------------------------------

  // select only matters while the count is nonzero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_LOOK; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= trk_r.push_sel;
      end
    end
  end

endmodule

// ==== design/r_arbiter.sv ====
//--------------------------------------------------------------------------
// round-robin merge of downstream R beats with lock-in until handshake
// downstream r_valid must stay high until its ready, per AXI rules
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module r_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // downstream R beats
  input  rd_demux_pkg::port_vec_t                           m_r_valid_i,
  input  rd_demux_pkg::id_t   [rd_demux_pkg::NUM_PORTS-1:0] m_r_id_i,
  input  rd_demux_pkg::data_t [rd_demux_pkg::NUM_PORTS-1:0] m_r_data_i,
  input  rd_demux_pkg::port_vec_t                           m_r_last_i,
  output rd_demux_pkg::port_vec_t                           m_r_ready_o,
  // upstream R beat and the port it came from
  output logic                                              r_valid_o,
  input  logic                                              r_ready_i,
  output rd_demux_pkg::id_t                                 r_id_o,
  output rd_demux_pkg::data_t                               r_data_o,
  output logic                                              r_last_o,
  output rd_demux_pkg::sel_t                                r_idx_o,
  // burst retirement towards the tracker
  rd_track_if.arbiter                                       trk
);
  import rd_demux_pkg::*;

  // port with the highest priority in the next free arbitration
  sel_t rr_q;
  // grant held while a beat waits for upstream ready
  logic lock_q;
  sel_t idx_q;
  sel_t pick;
  sel_t idx;
  logic r_hs;

  // first valid port at or after the pointer
  always_comb begin
    sel_t cand;
    logic found;
    pick  = rr_q;
    found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = sel_t'((int'(rr_q) + k) % NUM_PORTS);
      if (!found && m_r_valid_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  assign idx       = lock_q ? idx_q : pick;
  assign r_valid_o = m_r_valid_i[idx];
  assign r_hs      = r_valid_o & r_ready_i;
  assign r_idx_o   = idx;

  // winner's beat, zeros while idle
  assign r_id_o   = r_valid_o ? m_r_id_i[idx] : '0;
  assign r_data_o = r_valid_o ? m_r_data_i[idx] : '0;
  assign r_last_o = r_valid_o & m_r_last_i[idx];

  // ready goes back to the winner only
  assign m_r_ready_o = r_valid_o ? port_vec_t'(r_ready_i) << idx : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      lock_q <= r_valid_o & ~r_ready_i;
      idx_q  <= idx;
      // move past the served port
      if (r_hs) begin
        rr_q <= sel_t'((int'(idx) + 1) % NUM_PORTS);
      end
    end
  end

  // last beat accepted upstream retires one burst
  assign trk.pop    = r_hs & r_last_o;
  assign trk.pop_id = r_id_o[LOOK_W-1:0];

endmodule

// ==== design/rd_demux_top.sv ====
//--------------------------------------------------------------------------
// AXI read demux, one upstream port to NUM_PORTS downstream ports
// an AR waits while its low ID bits are in flight on another port
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module rd_demux_top (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // upstream AR
  input  logic                                              ar_valid_i,
  output logic                                              ar_ready_o,
  input  rd_demux_pkg::id_t                                 ar_id_i,
  input  rd_demux_pkg::addr_t                               ar_addr_i,
  input  rd_demux_pkg::len_t                                ar_len_i,
  input  rd_demux_pkg::sel_t                                ar_sel_i,
  // upstream R
  output logic                                              r_valid_o,
  input  logic                                              r_ready_i,
  output rd_demux_pkg::id_t                                 r_id_o,
  output rd_demux_pkg::data_t                               r_data_o,
  output logic                                              r_last_o,
  // downstream AR
  output rd_demux_pkg::port_vec_t                           m_ar_valid_o,
  input  rd_demux_pkg::port_vec_t                           m_ar_ready_i,
  output rd_demux_pkg::id_t   [rd_demux_pkg::NUM_PORTS-1:0] m_ar_id_o,
  output rd_demux_pkg::addr_t [rd_demux_pkg::NUM_PORTS-1:0] m_ar_addr_o,
  output rd_demux_pkg::len_t  [rd_demux_pkg::NUM_PORTS-1:0] m_ar_len_o,
  // downstream R
  input  rd_demux_pkg::port_vec_t                           m_r_valid_i,
  input  rd_demux_pkg::id_t   [rd_demux_pkg::NUM_PORTS-1:0] m_r_id_i,
  input  rd_demux_pkg::data_t [rd_demux_pkg::NUM_PORTS-1:0] m_r_data_i,
  input  rd_demux_pkg::port_vec_t                           m_r_last_i,
  output rd_demux_pkg::port_vec_t                           m_r_ready_o,
  // source port of the current upstream beat
  output rd_demux_pkg::sel_t                                r_idx_o
);
  import rd_demux_pkg::*;

  rd_track_if trk_bus ();

  // AR payload goes to every port, valid picks the target
  assign m_ar_id_o   = {NUM_PORTS{ar_id_i}};
  assign m_ar_addr_o = {NUM_PORTS{ar_addr_i}};
  assign m_ar_len_o  = {NUM_PORTS{ar_len_i}};

  ar_router u_ar_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_sel_i     (ar_sel_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .trk          (trk_bus.router)
  );

  // both views connect to the one tracker bus
  id_tracker u_id_tracker (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .trk_r   (trk_bus.tracker),
    .trk_a   (trk_bus)
  );

  r_arbiter u_r_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_last_i  (m_r_last_i),
    .m_r_ready_o (m_r_ready_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_last_o    (r_last_o),
    .r_idx_o     (r_idx_o),
    .trk         (trk_bus.arbiter)
  );

endmodule

// ==== tests/tb_rd_demux.sv ====
//--------------------------------------------------------------------------
// table-driven testbench for the read demux with four behavioral slaves
// slaves return len+1 beats, data = address + beat, held rows wait for release
// expected grants and tracker state come from a small reference model
//--------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_rd_demux;
  import rd_demux_pkg::*;

  // table size and cycle budget per row
  localparam int ROWS      = 21;
  localparam int ROW_LIMIT = 40;
  localparam int MAX_CYC   = ROWS * ROW_LIMIT;

  typedef struct packed {
    id_t   id;
    sel_t  sel;
    addr_t addr;
    len_t  len;
    logic  hold;
  } row_t;

  // one burst queued in a slave
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    logic  hold;
  } ent_t;

  logic clk_i;
  logic rst_n_i;
  logic ar_valid_i;
  logic ar_ready_o;
  id_t ar_id_i;
  addr_t ar_addr_i;
  len_t ar_len_i;
  sel_t ar_sel_i;
  logic r_valid_o;
  logic r_ready_i;
  id_t r_id_o;
  data_t r_data_o;
  logic r_last_o;
  port_vec_t m_ar_valid_o;
  port_vec_t m_ar_ready_i;
  id_t [NUM_PORTS-1:0] m_ar_id_o;
  addr_t [NUM_PORTS-1:0] m_ar_addr_o;
  len_t [NUM_PORTS-1:0] m_ar_len_o;
  port_vec_t m_r_valid_i;
  id_t [NUM_PORTS-1:0] m_r_id_i;
  data_t [NUM_PORTS-1:0] m_r_data_i;
  port_vec_t m_r_last_i;
  port_vec_t m_r_ready_o;
  sel_t r_idx_o;

  row_t tbl [ROWS];
  // hold flag of the offered row, and whether held bursts stay parked
  logic ar_hold;
  logic hold_on;
  // slave state
  ent_t slv_q [NUM_PORTS][$];
  len_t beat [NUM_PORTS] = '{default: '0};
  port_vec_t started = '0;
  // reference model of the tracker, the AR lock and the R grant
  cnt_t mdl_cnt [NUM_LOOK] = '{default: '0};
  sel_t mdl_sel [NUM_LOOK] = '{default: '0};
  logic ar_offered = 1'b0;
  logic r_stall = 1'b0;
  sel_t rr_ptr = '0;
  sel_t grant = '0;
  int beats_seen = 0;
  int beats_exp = 0;
  int contention = 0;
  int cycles = 0;

  rd_demux_top dut_i (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // first valid port at or after the round-robin pointer
  function automatic sel_t next_grant(input sel_t ptr, input port_vec_t v);
    sel_t c;
    for (int k = 0; k < NUM_PORTS; k++) begin
      c = ptr + sel_t'(k);
      if (v[c]) return c;
    end
    return ptr;
  endfunction

  function automatic logic model_full();
    for (int i = 0; i < NUM_LOOK; i++) begin
      if (&mdl_cnt[look_t'(i)]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // id, select, address, len, hold
  task automatic load_rows();
    tbl[0]  = '{4'h1, 2'd0, 16'h0100, 4'd3, 1'b0};
    tbl[1]  = '{4'h2, 2'd1, 16'h0200, 4'd0, 1'b0};
    tbl[2]  = '{4'h3, 2'd2, 16'h0300, 4'd1, 1'b0};
    tbl[3]  = '{4'h8, 2'd3, 16'h0400, 4'd2, 1'b0};
    tbl[4]  = '{4'h5, 2'd0, 16'h0500, 4'd7, 1'b0};
    // slot 2 bound to port 1, so the next row waits for its last beat
    tbl[5]  = '{4'h6, 2'd1, 16'h0600, 4'd5, 1'b0};
    tbl[6]  = '{4'hA, 2'd2, 16'h0700, 4'd1, 1'b0};
    // parked on all four ports, released together by the row after
    tbl[7]  = '{4'h0, 2'd0, 16'h1000, 4'd3, 1'b1};
    tbl[8]  = '{4'h1, 2'd1, 16'h1100, 4'd3, 1'b1};
    tbl[9]  = '{4'h2, 2'd2, 16'h1200, 4'd3, 1'b1};
    tbl[10] = '{4'h3, 2'd3, 16'h1300, 4'd3, 1'b1};
    tbl[11] = '{4'h4, 2'd0, 16'h1400, 4'd0, 1'b0};
    // seven parked bursts saturate slot 3, the eighth has to wait
    tbl[12] = '{4'h7, 2'd2, 16'h2000, 4'd1, 1'b1};
    tbl[13] = '{4'h7, 2'd2, 16'h2010, 4'd1, 1'b1};
    tbl[14] = '{4'h7, 2'd2, 16'h2020, 4'd1, 1'b1};
    tbl[15] = '{4'h7, 2'd2, 16'h2030, 4'd1, 1'b1};
    tbl[16] = '{4'h7, 2'd2, 16'h2040, 4'd1, 1'b1};
    tbl[17] = '{4'h7, 2'd2, 16'h2050, 4'd1, 1'b1};
    tbl[18] = '{4'h7, 2'd2, 16'h2060, 4'd1, 1'b1};
    tbl[19] = '{4'h7, 2'd2, 16'h2070, 4'd1, 1'b0};
    tbl[20] = '{4'hC, 2'd3, 16'h3100, 4'd3, 1'b0};
  endtask

  //--------------------------------------------------------------------------
  // slave models and upstream ready, driven 1 ns after the edge
  //--------------------------------------------------------------------------

  always @(posedge clk_i) begin
    sel_t ps;
    ent_t e;
    #1;
    r_ready_i = 1'($urandom());
    for (int p = 0; p < NUM_PORTS; p++) begin
      ps = sel_t'(p);
      m_ar_ready_i[ps] = 1'($urandom());
      // a burst once started keeps its valid until the last beat
      if (slv_q[ps].size() != 0 && (started[ps] || !(slv_q[ps][0].hold && hold_on))) begin
        e = slv_q[ps][0];
        started[ps] = 1'b1;
        m_r_valid_i[ps] = 1'b1;
        m_r_id_i[ps] = e.id;
        m_r_data_i[ps] = data_t'(e.addr) + data_t'(beat[ps]);
        m_r_last_i[ps] = (beat[ps] == e.len);
      end else begin
        m_r_valid_i[ps] = 1'b0;
        m_r_id_i[ps] = '0;
        m_r_data_i[ps] = '0;
        m_r_last_i[ps] = 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // monitor, sampled at the falling edge where everything has settled
  //--------------------------------------------------------------------------

  always @(negedge clk_i) begin
    look_t lk;
    logic exp_v;
    logic push;
    logic pop;
    look_t pop_lk;
    ent_t e;
    if (rst_n_i) begin
      // AR steering and the per-ID ordering rule
      lk = ar_id_i[LOOK_W-1:0];
      exp_v = ar_offered || (ar_valid_i && !model_full() &&
              (mdl_cnt[lk] == '0 || mdl_sel[lk] == ar_sel_i));
      compare_values(64'(m_ar_valid_o), 64'(port_vec_t'(exp_v) << ar_sel_i), "m_ar_valid_o");
      compare_values(64'(ar_ready_o), 64'(exp_v && m_ar_ready_i[ar_sel_i]), "ar_ready_o");
      // AR payload reaches every port unchanged
      for (int p = 0; p < NUM_PORTS; p++) begin
        compare_values(64'(m_ar_id_o[p]), 64'(ar_id_i), "m_ar_id_o");
        compare_values(64'(m_ar_addr_o[p]), 64'(ar_addr_i), "m_ar_addr_o");
        compare_values(64'(m_ar_len_o[p]), 64'(ar_len_i), "m_ar_len_o");
      end
      push = exp_v && m_ar_ready_i[ar_sel_i];
      ar_offered = exp_v && !push;
      if (push) begin
        e = '{ar_id_i, ar_addr_i, ar_len_i, ar_hold};
        slv_q[ar_sel_i].push_back(e);
      end
      // R merge, grant held while stalled
      pop = 1'b0;
      pop_lk = '0;
      compare_values(64'(r_valid_o), 64'(|m_r_valid_i), "r_valid_o");
      if (!r_stall) begin
        grant = next_grant(rr_ptr, m_r_valid_i);
        if (&m_r_valid_i) contention++;
      end
      if (r_valid_o) begin
        e = slv_q[grant][0];
        compare_values(64'(r_idx_o), 64'(grant), "r_idx_o");
        compare_values(64'(r_id_o), 64'(e.id), "r_id_o");
        compare_values(64'(r_data_o), 64'(data_t'(e.addr) + data_t'(beat[grant])), "r_data_o");
        compare_values(64'(r_last_o), 64'(beat[grant] == e.len), "r_last_o");
        compare_values(64'(m_r_ready_o), 64'(port_vec_t'(r_ready_i) << grant), "m_r_ready_o");
        if (r_ready_i) begin
          beats_seen++;
          rr_ptr = grant + sel_t'(1);
          if (beat[grant] == e.len) begin
            void'(slv_q[grant].pop_front());
            beat[grant] = '0;
            started[grant] = 1'b0;
            pop = 1'b1;
            pop_lk = e.id[LOOK_W-1:0];
          end else begin
            beat[grant] = beat[grant] + len_t'(1);
          end
        end
      end else begin
        compare_values(64'(m_r_ready_o), 64'(0), "m_r_ready_o while idle");
        // idle upstream beat carries zeros
        compare_values(64'(r_id_o), 64'(0), "r_id_o while idle");
        compare_values(64'(r_data_o), 64'(0), "r_data_o while idle");
        compare_values(64'(r_last_o), 64'(0), "r_last_o while idle");
      end
      r_stall = r_valid_o && !r_ready_i;
      // push and pop to one slot cancel out
      if (push) begin
        mdl_cnt[lk] = mdl_cnt[lk] + cnt_t'(1);
        mdl_sel[lk] = ar_sel_i;
      end
      if (pop) mdl_cnt[pop_lk] = mdl_cnt[pop_lk] - cnt_t'(1);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", MAX_CYC);
      abort_run();
    end
  end

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  initial begin
    void'($urandom(97));
    load_rows();
    rst_n_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_sel_i = '0;
    ar_hold = 1'b0;
    hold_on = 1'b0;
    r_ready_i = 1'b0;
    m_ar_ready_i = '0;
    m_r_valid_i = '0;
    m_r_id_i = '0;
    m_r_data_i = '0;
    m_r_last_i = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      hold_on = tbl[i].hold;
      @(posedge clk_i);
      #1;
      ar_valid_i = 1'b1;
      ar_id_i = tbl[i].id;
      ar_sel_i = tbl[i].sel;
      ar_addr_i = tbl[i].addr;
      ar_len_i = tbl[i].len;
      ar_hold = tbl[i].hold;
      beats_exp += int'(tbl[i].len) + 1;
      @(negedge clk_i);
      while (!ar_ready_o) @(negedge clk_i);
    end
    hold_on = 1'b0;
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
    // drain every burst, the cycle counter bounds the wait
    while (beats_seen != beats_exp) @(negedge clk_i);
    @(posedge clk_i);
    compare_values(64'(contention != 0), 64'(1), "no cycle with all ports returning beats");
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== tb.f ====
design/rd_demux_pkg.sv
design/rd_track_if.sv
design/ar_router.sv
design/id_tracker.sv
design/r_arbiter.sv
design/rd_demux_top.sv
tests/tb_rd_demux.sv

// ==== Makefile ====
# Verilator build and run of the read demux testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rd_demux
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

SOURCES := $(wildcard design/*.sv) $(wildcard tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, not the exit status of the simulator
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
